//--- design/id_remap_consts.svh
`ifndef ID_REMAP_CONSTS_SVH
`define ID_REMAP_CONSTS_SVH

// Manager-side transaction ID width
`define REMAP_ID_IN_W 6

// Remap table depth per channel
`define REMAP_SLOTS 4

// Subordinate-side ID, one code per table slot
`define REMAP_SUB_ID_W $clog2(`REMAP_SLOTS)

// Outstanding transactions per slot, saturates at all ones
`define REMAP_CNT_W 2

// Request payload fields
`define REMAP_ADDR_W 16
`define REMAP_LEN_W 4

`endif

//--- design/id_remap_pkg.sv
`include "id_remap_consts.svh"

package id_remap_pkg;

    // AW request payload
    typedef struct packed {
        logic [`REMAP_ADDR_W-1:0] addr;
        logic [`REMAP_LEN_W-1:0]  len;
        logic [2:0]               size;
    } wr_payload_t;

    // AR request payload, prot in place of size
    typedef struct packed {
        logic [`REMAP_ADDR_W-1:0] addr;
        logic [`REMAP_LEN_W-1:0]  len;
        logic [2:0]               prot;
    } rd_payload_t;

    // Response beat (B or R without data)
    typedef struct packed {
        logic [1:0] resp;
        logic       last;
    } rsp_t;

    // One remap table entry as seen by allocator and restorer
    typedef struct packed {
        logic                      valid;
        logic [`REMAP_ID_IN_W-1:0] in_id;
        logic [`REMAP_CNT_W-1:0]   count;
    } slot_state_t;

endpackage

//--- design/remap_slot.sv
`timescale 1ns/1ps
`include "id_remap_consts.svh"

module remap_slot (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      alloc_i,
    input  logic [`REMAP_ID_IN_W-1:0] new_id_i,
    input  logic                      release_i,
    output id_remap_pkg::slot_state_t state_o
);

    localparam logic [`REMAP_CNT_W-1:0] CNT_MAX = '1;
    localparam logic [`REMAP_CNT_W-1:0] CNT_ONE = {{(`REMAP_CNT_W-1){1'b0}}, 1'b1};

    id_remap_pkg::slot_state_t state_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= '0;
        end else begin
            case ({alloc_i, release_i})
                2'b10: begin
                    // A free slot takes the new ID, a busy one already holds it
                    if (!state_q.valid) begin
                        state_q.valid <= 1'b1;
                        state_q.in_id <= new_id_i;
                    end
                    state_q.count <= state_q.count + CNT_ONE;
                end
                2'b01: begin
                    state_q.count <= state_q.count - CNT_ONE;
                    // Last outstanding transaction gone
                    if (state_q.count == CNT_ONE) begin
                        state_q.valid <= 1'b0;
                    end
                end
                // Idle, or allocate and release together: count holds
                default: begin
                    state_q <= state_q;
                end
            endcase
        end
    end

    assign state_o = state_q;

    // Restorer must only release a slot that is in use
    a_release_valid: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        release_i |-> state_q.valid
    );

    // Allocator stalls before the counter could wrap
    a_alloc_not_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        alloc_i |-> (state_q.count != CNT_MAX)
    );

endmodule

//--- design/slot_allocator.sv
`timescale 1ns/1ps
`include "id_remap_consts.svh"

module slot_allocator (
    input  logic [`REMAP_ID_IN_W-1:0]  req_id_i,
    input  id_remap_pkg::slot_state_t  slots_i [`REMAP_SLOTS],
    output logic [`REMAP_SLOTS-1:0]    alloc_o,
    output logic [`REMAP_SUB_ID_W-1:0] slot_idx_o,
    output logic                       stall_o
);

    logic [`REMAP_SLOTS-1:0]    match;
    logic [`REMAP_SLOTS-1:0]    free;
    logic [`REMAP_SUB_ID_W-1:0] match_idx;
    logic [`REMAP_SUB_ID_W-1:0] free_idx;
    logic                       match_any;
    logic                       free_any;

    always_comb begin
        match     = '0;
        free      = '0;
        match_idx = '0;
        free_idx  = '0;
        // Walk downwards so the lowest free index is the one kept
        for (int i = `REMAP_SLOTS - 1; i >= 0; i--) begin
            match[i] = slots_i[i].valid && (slots_i[i].in_id == req_id_i);
            free[i]  = !slots_i[i].valid;
            if (match[i]) begin
                match_idx = i[`REMAP_SUB_ID_W-1:0];
            end
            if (free[i]) begin
                free_idx = i[`REMAP_SUB_ID_W-1:0];
            end
        end
    end

    assign match_any = |match;
    assign free_any  = |free;

    // Same ID must stay on its slot to keep ordering, even if that slot is full
    assign stall_o = match_any ? (&slots_i[match_idx].count) : !free_any;

    assign slot_idx_o = match_any ? match_idx : free_idx;

    always_comb begin
        alloc_o             = '0;
        alloc_o[slot_idx_o] = !stall_o;
    end

    // Two slots holding the same ID would show up here as two grants
    always_comb begin
        a_alloc_onehot: assert ($onehot0(alloc_o | match));
    end

endmodule

//--- design/response_restorer.sv
`timescale 1ns/1ps
`include "id_remap_consts.svh"

module response_restorer #(
    parameter bit RELEASE_ON_LAST = 1'b0
) (
    input  logic [`REMAP_SUB_ID_W-1:0] rsp_id_i,
    input  id_remap_pkg::slot_state_t  slots_i [`REMAP_SLOTS],
    input  logic                       fire_i,
    input  logic                       last_i,
    output logic [`REMAP_ID_IN_W-1:0]  orig_id_o,
    output logic                       hit_o,
    output logic [`REMAP_SLOTS-1:0]    release_o
);

    id_remap_pkg::slot_state_t sel;
    logic                      rel_en;

    // Subordinate ID is the slot index
    assign sel       = slots_i[rsp_id_i];
    assign orig_id_o = sel.in_id;
    assign hit_o     = sel.valid;

    // Read bursts keep the slot until their final beat
    assign rel_en = fire_i && (!RELEASE_ON_LAST || last_i);

    always_comb begin
        release_o           = '0;
        release_o[rsp_id_i] = rel_en;
    end

endmodule

//--- design/id_remap_channel.sv
`timescale 1ns/1ps
`include "id_remap_consts.svh"

module id_remap_channel #(
    parameter type payload_t       = id_remap_pkg::wr_payload_t,
    parameter bit  RELEASE_ON_LAST = 1'b0
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // Manager request
    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    input  logic [`REMAP_ID_IN_W-1:0]  req_id_i,
    input  payload_t                   req_payload_i,
    // Subordinate request
    output logic                       sub_req_valid_o,
    input  logic                       sub_req_ready_i,
    output logic [`REMAP_SUB_ID_W-1:0] sub_req_id_o,
    output payload_t                   sub_req_payload_o,
    // Subordinate response
    input  logic                       sub_rsp_valid_i,
    output logic                       sub_rsp_ready_o,
    input  logic [`REMAP_SUB_ID_W-1:0] sub_rsp_id_i,
    input  id_remap_pkg::rsp_t         sub_rsp_i,
    // Manager response
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,
    output logic [`REMAP_ID_IN_W-1:0]  rsp_id_o,
    output id_remap_pkg::rsp_t         rsp_o
);

    id_remap_pkg::slot_state_t  slots [`REMAP_SLOTS];
    logic [`REMAP_SLOTS-1:0]    grant;
    logic [`REMAP_SLOTS-1:0]    alloc;
    logic [`REMAP_SLOTS-1:0]    release_vec;
    logic                       stall;
    logic                       hit;
    logic                       req_fire;
    logic                       rsp_fire;

    // Request path, stalled when the table cannot take this ID
    assign sub_req_valid_o   = req_valid_i & ~stall;
    assign req_ready_o       = sub_req_ready_i & ~stall;
    assign sub_req_payload_o = req_payload_i;
    assign req_fire          = req_valid_i & req_ready_o;
    assign alloc             = grant & {`REMAP_SLOTS{req_fire}};

    // Response path, blocked while the addressed slot is empty
    assign rsp_valid_o     = sub_rsp_valid_i & hit;
    assign sub_rsp_ready_o = rsp_ready_i & hit;
    assign rsp_o           = sub_rsp_i;
    assign rsp_fire        = rsp_valid_o & rsp_ready_i;

    slot_allocator i_allocator (
        .req_id_i   ( req_id_i     ),
        .slots_i    ( slots        ),
        .alloc_o    ( grant        ),
        .slot_idx_o ( sub_req_id_o ),
        .stall_o    ( stall        )
    );

    for (genvar g = 0; g < `REMAP_SLOTS; g++) begin : g_slot
        remap_slot i_slot (
            .clk_i     ( clk_i          ),
            .rst_ni    ( rst_ni         ),
            .alloc_i   ( alloc[g]       ),
            .new_id_i  ( req_id_i       ),
            .release_i ( release_vec[g] ),
            .state_o   ( slots[g]       )
        );
    end

    response_restorer #(
        .RELEASE_ON_LAST ( RELEASE_ON_LAST )
    ) i_restorer (
        .rsp_id_i  ( sub_rsp_id_i   ),
        .slots_i   ( slots          ),
        .fire_i    ( rsp_fire       ),
        .last_i    ( sub_rsp_i.last ),
        .orig_id_o ( rsp_id_o       ),
        .hit_o     ( hit            ),
        .release_o ( release_vec    )
    );

    // Subordinate answers only IDs this channel handed out
    a_rsp_hit: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        sub_rsp_valid_i |-> hit
    );

endmodule

//--- design/id_remap_top.sv
`timescale 1ns/1ps
`include "id_remap_consts.svh"

module id_remap_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // Write request, manager and subordinate side
    input  logic                        aw_valid_i,
    output logic                        aw_ready_o,
    input  logic [`REMAP_ID_IN_W-1:0]   aw_id_i,
    input  id_remap_pkg::wr_payload_t   aw_payload_i,
    output logic                        aw_sub_valid_o,
    input  logic                        aw_sub_ready_i,
    output logic [`REMAP_SUB_ID_W-1:0]  aw_sub_id_o,
    output id_remap_pkg::wr_payload_t   aw_sub_payload_o,
    // Write response, subordinate and manager side
    input  logic                        b_sub_valid_i,
    output logic                        b_sub_ready_o,
    input  logic [`REMAP_SUB_ID_W-1:0]  b_sub_id_i,
    input  id_remap_pkg::rsp_t          b_sub_i,
    output logic                        b_valid_o,
    input  logic                        b_ready_i,
    output logic [`REMAP_ID_IN_W-1:0]   b_id_o,
    output id_remap_pkg::rsp_t          b_o,
    // Read request, manager and subordinate side
    input  logic                        ar_valid_i,
    output logic                        ar_ready_o,
    input  logic [`REMAP_ID_IN_W-1:0]   ar_id_i,
    input  id_remap_pkg::rd_payload_t   ar_payload_i,
    output logic                        ar_sub_valid_o,
    input  logic                        ar_sub_ready_i,
    output logic [`REMAP_SUB_ID_W-1:0]  ar_sub_id_o,
    output id_remap_pkg::rd_payload_t   ar_sub_payload_o,
    // Read response beats, subordinate and manager side
    input  logic                        r_sub_valid_i,
    output logic                        r_sub_ready_o,
    input  logic [`REMAP_SUB_ID_W-1:0]  r_sub_id_i,
    input  id_remap_pkg::rsp_t          r_sub_i,
    output logic                        r_valid_o,
    input  logic                        r_ready_i,
    output logic [`REMAP_ID_IN_W-1:0]   r_id_o,
    output id_remap_pkg::rsp_t          r_o
);

    // Every B frees its write
    id_remap_channel #(
        .payload_t       ( id_remap_pkg::wr_payload_t ),
        .RELEASE_ON_LAST ( 1'b0                       )
    ) i_wr_channel (
        .clk_i             ( clk_i            ),
        .rst_ni            ( rst_ni           ),
        .req_valid_i       ( aw_valid_i       ),
        .req_ready_o       ( aw_ready_o       ),
        .req_id_i          ( aw_id_i          ),
        .req_payload_i     ( aw_payload_i     ),
        .sub_req_valid_o   ( aw_sub_valid_o   ),
        .sub_req_ready_i   ( aw_sub_ready_i   ),
        .sub_req_id_o      ( aw_sub_id_o      ),
        .sub_req_payload_o ( aw_sub_payload_o ),
        .sub_rsp_valid_i   ( b_sub_valid_i    ),
        .sub_rsp_ready_o   ( b_sub_ready_o    ),
        .sub_rsp_id_i      ( b_sub_id_i       ),
        .sub_rsp_i         ( b_sub_i          ),
        .rsp_valid_o       ( b_valid_o        ),
        .rsp_ready_i       ( b_ready_i        ),
        .rsp_id_o          ( b_id_o           ),
        .rsp_o             ( b_o              )
    );

    // Reads free their slot on the last R beat
    id_remap_channel #(
        .payload_t       ( id_remap_pkg::rd_payload_t ),
        .RELEASE_ON_LAST ( 1'b1                       )
    ) i_rd_channel (
        .clk_i             ( clk_i            ),
        .rst_ni            ( rst_ni           ),
        .req_valid_i       ( ar_valid_i       ),
        .req_ready_o       ( ar_ready_o       ),
        .req_id_i          ( ar_id_i          ),
        .req_payload_i     ( ar_payload_i     ),
        .sub_req_valid_o   ( ar_sub_valid_o   ),
        .sub_req_ready_i   ( ar_sub_ready_i   ),
        .sub_req_id_o      ( ar_sub_id_o      ),
        .sub_req_payload_o ( ar_sub_payload_o ),
        .sub_rsp_valid_i   ( r_sub_valid_i    ),
        .sub_rsp_ready_o   ( r_sub_ready_o    ),
        .sub_rsp_id_i      ( r_sub_id_i       ),
        .sub_rsp_i         ( r_sub_i          ),
        .rsp_valid_o       ( r_valid_o        ),
        .rsp_ready_i       ( r_ready_i        ),
        .rsp_id_o          ( r_id_o           ),
        .rsp_o             ( r_o              )
    );

endmodule

//--- tb/id_remap_tb.sv
`timescale 1ns/1ps
`include "id_remap_consts.svh"

module id_remap_tb;

    localparam int          ID_W      = `REMAP_ID_IN_W;
    localparam int          SUB_W     = `REMAP_SUB_ID_W;
    localparam int          PL_W      = $bits(id_remap_pkg::wr_payload_t);
    localparam int          CYCLE_NS  = 10;
    localparam int          OP_CYCLES = 20;
    localparam int          WAIT_MAX  = 8;
    localparam int          STALL_CYC = 3;
    localparam int          BP_MAX    = 3;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic                      clk;
    logic                      rst_n;
    logic                      aw_valid, aw_ready, aw_sub_valid, aw_sub_ready;
    logic [ID_W-1:0]           aw_id;
    logic [SUB_W-1:0]          aw_sub_id;
    id_remap_pkg::wr_payload_t aw_payload, aw_sub_payload;
    logic                      b_sub_valid, b_sub_ready, b_valid, b_ready;
    logic [SUB_W-1:0]          b_sub_id;
    logic [ID_W-1:0]           b_id;
    id_remap_pkg::rsp_t        b_sub, b_rsp;
    logic                      ar_valid, ar_ready, ar_sub_valid, ar_sub_ready;
    logic [ID_W-1:0]           ar_id;
    logic [SUB_W-1:0]          ar_sub_id;
    id_remap_pkg::rd_payload_t ar_payload, ar_sub_payload;
    logic                      r_sub_valid, r_sub_ready, r_valid, r_ready;
    logic [SUB_W-1:0]          r_sub_id;
    logic [ID_W-1:0]           r_id;
    id_remap_pkg::rsp_t        r_sub, r_rsp;

    // One queue entry per stimulus line
    logic [23:0] op_q [$];
    logic [7:0]  ch_q [$];
    int          id_q [$];
    int          last_q [$];
    int          exp_q [$];
    int          n_ops;
    logic [15:0] lfsr;

    id_remap_top DUT (
        .clk_i (clk), .rst_ni (rst_n),
        .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_id_i (aw_id),
        .aw_payload_i (aw_payload), .aw_sub_valid_o (aw_sub_valid),
        .aw_sub_ready_i (aw_sub_ready), .aw_sub_id_o (aw_sub_id),
        .aw_sub_payload_o (aw_sub_payload),
        .b_sub_valid_i (b_sub_valid), .b_sub_ready_o (b_sub_ready), .b_sub_id_i (b_sub_id),
        .b_sub_i (b_sub), .b_valid_o (b_valid), .b_ready_i (b_ready), .b_id_o (b_id),
        .b_o (b_rsp),
        .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_id_i (ar_id),
        .ar_payload_i (ar_payload), .ar_sub_valid_o (ar_sub_valid),
        .ar_sub_ready_i (ar_sub_ready), .ar_sub_id_o (ar_sub_id),
        .ar_sub_payload_o (ar_sub_payload),
        .r_sub_valid_i (r_sub_valid), .r_sub_ready_o (r_sub_ready), .r_sub_id_i (r_sub_id),
        .r_sub_i (r_sub), .r_valid_o (r_valid), .r_ready_i (r_ready), .r_id_o (r_id),
        .r_o (r_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CYCLE_NS / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] %0d ns: %s expected 0x%0h, got 0x%0h",
                                $time, name, exp, act));
        end
    endtask

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit with the newest bit in the LSB
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          cnt;
        string       line;
        logic [23:0] op;
        logic [7:0]  ch;
        int          id;
        int          last;
        int          exp_v;
        fd = $fopen("tb/id_remap_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file tb/id_remap_stim.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                op  = '0;
                cnt = $sscanf(line, "%s %s %d %d %d", op, ch, id, last, exp_v);
                if (cnt == 5) begin
                    op_q.push_back(op);
                    ch_q.push_back(ch);
                    id_q.push_back(id);
                    last_q.push_back(last);
                    exp_q.push_back(exp_v);
                end else if (cnt > 0 && op != {16'h0000, "#"}) begin
                    abort_run({"Malformed stimulus line: ", line});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_req(input bit is_w, input logic v, input logic [ID_W-1:0] id,
                             input logic [PL_W-1:0] pl);
        if (is_w) begin
            aw_valid   <= v;
            aw_id      <= id;
            aw_payload <= pl;
        end else begin
            ar_valid   <= v;
            ar_id      <= id;
            ar_payload <= pl;
        end
    endtask

    task automatic drive_rsp(input bit is_w, input logic v, input logic [SUB_W-1:0] id,
                             input logic [2:0] rsp, input logic ready);
        if (is_w) begin
            b_sub_valid <= v;
            b_sub_id    <= id;
            b_sub       <= rsp;
            b_ready     <= ready;
        end else begin
            r_sub_valid <= v;
            r_sub_id    <= id;
            r_sub       <= rsp;
            r_ready     <= ready;
        end
    endtask

    // Manager request held until the remapper accepts it
    task automatic do_req(input bit is_w, input int id, input int exp_sub);
        logic [31:0] pl;
        int          waited;
        string       pfx;
        pfx    = is_w ? "aw" : "ar";
        waited = 0;
        rand_bits(PL_W, pl);
        @(posedge clk);
        drive_req(is_w, 1'b1, id[ID_W-1:0], pl[PL_W-1:0]);
        @(negedge clk);
        while (!(is_w ? aw_ready : ar_ready)) begin
            if (waited >= WAIT_MAX) begin
                abort_run($sformatf("Request with ID %0d on %s was never accepted", id, pfx));
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        check_val({pfx, "_sub_valid_o"}, 1, 32'(is_w ? aw_sub_valid : ar_sub_valid));
        check_val({pfx, "_sub_id_o"}, exp_sub, 32'(is_w ? aw_sub_id : ar_sub_id));
        check_val({pfx, "_sub_payload_o"}, 32'(pl[PL_W-1:0]),
                  32'(is_w ? PL_W'(aw_sub_payload) : PL_W'(ar_sub_payload)));
        @(posedge clk);
        drive_req(is_w, 1'b0, id[ID_W-1:0], pl[PL_W-1:0]);
    endtask

    // Request that the table must refuse while it is offered
    task automatic do_stall(input bit is_w, input int id);
        string pfx;
        pfx = is_w ? "aw" : "ar";
        @(posedge clk);
        drive_req(is_w, 1'b1, id[ID_W-1:0], '0);
        repeat (STALL_CYC) begin
            @(negedge clk);
            check_val({pfx, "_ready_o"}, 0, 32'(is_w ? aw_ready : ar_ready));
            check_val({pfx, "_sub_valid_o"}, 0, 32'(is_w ? aw_sub_valid : ar_sub_valid));
        end
        @(posedge clk);
        drive_req(is_w, 1'b0, id[ID_W-1:0], '0);
    endtask

    // Response beat with rsp_ready held low on random cycles
    task automatic do_rsp(input bit is_w, input int sub_id, input int last, input int exp_id);
        logic [31:0] rb;
        logic [2:0]  rsp;
        logic        ready;
        int          low_run;
        bit          done;
        string       pfx;
        pfx     = is_w ? "b" : "r";
        low_run = 0;
        done    = 1'b0;
        rand_bits(3, rb);
        // Every B releases its slot whatever its last bit says
        rsp = is_w ? rb[2:0] : {rb[1:0], last[0]};
        while (!done) begin
            rand_bits(1, rb);
            ready = rb[0] | (low_run >= BP_MAX);
            @(posedge clk);
            drive_rsp(is_w, 1'b1, sub_id[SUB_W-1:0], rsp, ready);
            @(negedge clk);
            check_val({pfx, "_valid_o"}, 1, 32'(is_w ? b_valid : r_valid));
            check_val({pfx, "_id_o"}, exp_id, 32'(is_w ? b_id : r_id));
            check_val({pfx, "_o"}, 32'(rsp), 32'(is_w ? 3'(b_rsp) : 3'(r_rsp)));
            check_val({pfx, "_sub_ready_o"}, 32'(ready), 32'(is_w ? b_sub_ready : r_sub_ready));
            if (ready) begin
                done = 1'b1;
            end else begin
                low_run++;
            end
        end
        @(posedge clk);
        drive_rsp(is_w, 1'b0, sub_id[SUB_W-1:0], rsp, 1'b1);
    endtask

    task automatic run_op(input int k);
        bit is_w;
        is_w = (ch_q[k] == "W");
        if (!is_w && ch_q[k] != "R") begin
            abort_run($sformatf("Stimulus line %0d names an unknown channel", k));
        end else begin
            case (op_q[k])
                "REQ":   do_req(is_w, id_q[k], exp_q[k]);
                "STL":   do_stall(is_w, id_q[k]);
                "RSP":   do_rsp(is_w, id_q[k], last_q[k], exp_q[k]);
                default: abort_run($sformatf("Stimulus line %0d has an unknown operation", k));
            endcase
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        lfsr         = 16'd61802;
        n_ops        = 0;
        aw_valid     = 1'b0;
        aw_id        = '0;
        aw_payload   = '0;
        aw_sub_ready = 1'b1;
        b_sub_valid  = 1'b0;
        b_sub_id     = '0;
        b_sub        = '0;
        b_ready      = 1'b1;
        ar_valid     = 1'b0;
        ar_id        = '0;
        ar_payload   = '0;
        ar_sub_ready = 1'b1;
        r_sub_valid  = 1'b0;
        r_sub_id     = '0;
        r_sub        = '0;
        r_ready      = 1'b1;
        load_stim();
        if (op_q.size() == 0) begin
            abort_run("The stimulus file holds no operations");
        end
        n_ops = op_q.size();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // Empty table after reset
        @(negedge clk);
        check_val("aw_sub_valid_o", 0, 32'(aw_sub_valid));
        check_val("ar_sub_valid_o", 0, 32'(ar_sub_valid));
        check_val("b_valid_o", 0, 32'(b_valid));
        check_val("r_valid_o", 0, 32'(r_valid));
        check_val("aw_ready_o", 1, 32'(aw_ready));
        check_val("ar_ready_o", 1, 32'(ar_ready));
        // Request ready follows the subordinate while nothing stalls
        @(posedge clk);
        aw_sub_ready <= 1'b0;
        ar_sub_ready <= 1'b0;
        @(negedge clk);
        check_val("aw_ready_o", 0, 32'(aw_ready));
        check_val("ar_ready_o", 0, 32'(ar_ready));
        @(posedge clk);
        aw_sub_ready <= 1'b1;
        ar_sub_ready <= 1'b1;
        for (int k = 0; k < n_ops; k++) begin
            run_op(k);
        end
        @(posedge clk);
        $display("All tests passed");
        $finish;
    end

    // Budget grows with the number of stimulus lines
    initial begin
        wait (n_ops > 0);
        #(n_ops * OP_CYCLES * CYCLE_NS);
        abort_run($sformatf("Timeout: the %0d operations did not finish in time", n_ops));
    end

endmodule

//--- tb/id_remap_stim.txt
# op ch id last expected   (op is REQ, RSP or STL; ch is W or R)
# REQ and STL give the manager ID and the expected subordinate ID, RSP the reverse
REQ W 5  0 0
REQ W 17 0 1
REQ W 40 0 2
REQ R 40 0 0
REQ R 17 0 1
REQ W 17 0 1
RSP W 1  1 17
RSP R 0  0 40
REQ R 8  0 2
RSP W 1  1 17
REQ W 9  0 1
RSP R 0  0 40
RSP R 0  1 40
REQ R 11 0 0
REQ W 33 0 3
STL W 50 0 0
REQ W 33 0 3
REQ W 33 0 3
STL W 33 0 0
RSP W 3  1 33
REQ W 33 0 3
RSP W 0  1 5
REQ W 50 0 0
RSP R 1  1 17
RSP R 2  0 8
RSP R 2  1 8
RSP R 0  1 11
RSP W 3  1 33
RSP W 3  1 33
RSP W 3  1 33
RSP W 1  1 9
RSP W 2  1 40
RSP W 0  1 50
REQ W 60 0 0
RSP W 0  1 60

//--- src.f
+incdir+design
design/id_remap_pkg.sv
design/remap_slot.sv
design/slot_allocator.sv
design/response_restorer.sv
design/id_remap_channel.sv
design/id_remap_top.sv
tb/id_remap_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ID remapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module id_remap_tb \
    --Mdir obj_dir -o id_remap_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/id_remap_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
    echo "Simulation ended without a pass result"
    exit 1
fi
exit 0
